/* hdl/control_unit.sv */
module control_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  isa_pkg::opcode_t     opcode,
    input  isa_pkg::funct_t      funct,
    input  logic                 ov,
    input  logic                 lt,
    output logic                 pc_write,
    output logic                 branch,
    output logic                 mem_wr,
    output logic                 ir_write,
    output logic                 a_write,
    output logic                 b_write,
    output logic                 mdr_write,
    output logic                 aluout_write,
    output logic                 epc_write,
    output logic                 reg_write,
    output logic                 shift_src,
    output ctrl_pkg::src_a_t     alu_src_a,
    output ctrl_pkg::src_b_t     alu_src_b,
    output ctrl_pkg::alu_op_t    alu_op,
    output ctrl_pkg::reg_dst_t   reg_dst,
    output ctrl_pkg::wdata_sel_t reg_wdata_sel,
    output ctrl_pkg::addr_sel_t  iord,
    output ctrl_pkg::pc_src_t    pc_src,
    output ctrl_pkg::size_sel_t  mem_to_mdr,
    output ctrl_pkg::size_sel_t  b_to_mem,
    output ctrl_pkg::shift_op_t  shift_ctrl,
    output ctrl_pkg::cause_t     except_cause
);
    import ctrl_pkg::*;

    state_t    dispatch_state;
    state_t    state;
    shift_op_t dec_shift_op;
    shift_op_t shift_op;  // Latched at dispatch

    instr_decoder u_decoder (
        .opcode         (opcode),
        .funct          (funct),
        .dispatch_state (dispatch_state),
        .shift_op       (dec_shift_op)
    );

    ctrl_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .ov             (ov),
        .dispatch_state (dispatch_state),
        .shift_op_in    (dec_shift_op),
        .state          (state),
        .shift_op       (shift_op)
    );

    ctrl_signal_gen u_signal_gen (.*);

endmodule

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [5:0] {
        FETCH_WAIT_ST, FETCH_ST, DECODE_ST, DISPATCH_ST,
        ADD_ST, SUB_ST, AND_ST, ADDI_ST, ADDIU_ST,
        WB_RD_OV_ST, WB_RD_ST, WB_RT_OV_ST, WB_RT_ST,
        SLT_ST, SLTI_ST,
        SHIFT_IMM_ST, SHIFT_VAR_ST, SHIFT_OP_ST, SHIFT_WB_ST,
        MEM_ADDR_ST, MEM_WAIT_ST,
        LOAD_WORD_ST, LOAD_HALF_ST, LOAD_BYTE_ST, LOAD_WB_ST,
        STORE_WORD_ST, STORE_HALF_ST, STORE_BYTE_ST,
        JUMP_ST, JAL_ST, JAL_WB_ST, JR_ST,
        OPCODE_EXC_ST, OVERFLOW_EXC_ST, EPC_ST
    } state_t;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_PASS = 3'd0;
    localparam alu_op_t ALU_ADD  = 3'd1;
    localparam alu_op_t ALU_SUB  = 3'd2;
    localparam alu_op_t ALU_AND  = 3'd3;
    localparam alu_op_t ALU_SLT  = 3'd7;

    typedef logic [2:0] shift_op_t;
    localparam shift_op_t SHIFT_NONE        = 3'd0;
    localparam shift_op_t SHIFT_LOAD        = 3'd1;
    localparam shift_op_t SHIFT_LEFT        = 3'd2;
    localparam shift_op_t SHIFT_RIGHT_LOGIC = 3'd3;
    localparam shift_op_t SHIFT_RIGHT_ARITH = 3'd4;

    typedef logic [1:0] reg_dst_t;
    localparam reg_dst_t DST_RT = 2'd0;
    localparam reg_dst_t DST_RD = 2'd1;
    localparam reg_dst_t DST_RA = 2'd3;  // r31

    typedef logic [3:0] wdata_sel_t;
    localparam wdata_sel_t WD_ALUOUT = 4'd0;
    localparam wdata_sel_t WD_MDR    = 4'd1;
    localparam wdata_sel_t WD_ZERO   = 4'd5;
    localparam wdata_sel_t WD_ONE    = 4'd6;
    localparam wdata_sel_t WD_SHIFT  = 4'd7;

    typedef logic [2:0] addr_sel_t;
    localparam addr_sel_t ADDR_PC         = 3'd0;
    localparam addr_sel_t ADDR_ALUOUT     = 3'd1;
    localparam addr_sel_t ADDR_EXC_VECTOR = 3'd2;

    typedef logic [2:0] pc_src_t;
    localparam pc_src_t PC_ALU        = 3'd0;
    localparam pc_src_t PC_JUMP       = 3'd2;
    localparam pc_src_t PC_EPC_VECTOR = 3'd3;  // Handler address read from the vector

    typedef logic [1:0] size_sel_t;
    localparam size_sel_t SIZE_WORD = 2'd0;
    localparam size_sel_t SIZE_HALF = 2'd1;
    localparam size_sel_t SIZE_BYTE = 2'd2;

    typedef logic [1:0] cause_t;
    localparam cause_t CAUSE_OPCODE   = 2'd0;
    localparam cause_t CAUSE_OVERFLOW = 2'd1;

    typedef logic [1:0] src_a_t;
    localparam src_a_t SRC_A_PC  = 2'd0;
    localparam src_a_t SRC_A_REG = 2'd1;

    typedef logic [2:0] src_b_t;
    localparam src_b_t SRC_B_REG  = 3'd0;
    localparam src_b_t SRC_B_FOUR = 3'd1;
    localparam src_b_t SRC_B_IMM  = 3'd2;

    // Wait lengths in cycles
    localparam int FETCH_WAIT = 3;
    localparam int MEM_WAIT   = 2;
    localparam int EXC_WAIT   = 3;
    localparam int WAIT_CNT_W = $clog2(FETCH_WAIT > EXC_WAIT ?
                                       (FETCH_WAIT > MEM_WAIT ? FETCH_WAIT : MEM_WAIT) :
                                       (EXC_WAIT > MEM_WAIT ? EXC_WAIT : MEM_WAIT));

endpackage

/* hdl/ctrl_sequencer.sv */
module ctrl_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                ov,
    input  ctrl_pkg::state_t    dispatch_state,
    input  ctrl_pkg::shift_op_t shift_op_in,
    output ctrl_pkg::state_t    state,
    output ctrl_pkg::shift_op_t shift_op
);
    import ctrl_pkg::*;

    state_t                next_state;
    state_t                mem_class;  // Select state of the pending load or store
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic [WAIT_CNT_W-1:0] wait_last;
    logic                  in_wait;
    logic                  wait_done;

    always_comb begin
        in_wait   = 1'b1;
        wait_last = '0;
        case (state)
            FETCH_WAIT_ST:   wait_last = WAIT_CNT_W'(FETCH_WAIT - 1);
            MEM_WAIT_ST:     wait_last = WAIT_CNT_W'(MEM_WAIT - 1);
            OPCODE_EXC_ST,
            OVERFLOW_EXC_ST: wait_last = WAIT_CNT_W'(EXC_WAIT - 1);
            default:         in_wait = 1'b0;
        endcase
    end

    assign wait_done = (wait_cnt == wait_last);

    always_comb begin
        next_state = FETCH_WAIT_ST;  // Last cycle of an instruction
        case (state)
            FETCH_WAIT_ST: next_state = wait_done ? FETCH_ST : FETCH_WAIT_ST;
            FETCH_ST:      next_state = DECODE_ST;
            DECODE_ST:     next_state = DISPATCH_ST;
            DISPATCH_ST: begin
                if (dispatch_state inside {LOAD_WORD_ST, LOAD_HALF_ST, LOAD_BYTE_ST,
                                           STORE_WORD_ST, STORE_HALF_ST, STORE_BYTE_ST}) begin
                    next_state = MEM_ADDR_ST;  // Address and wait come first
                end else begin
                    next_state = dispatch_state;
                end
            end
            ADD_ST, SUB_ST: next_state = WB_RD_OV_ST;
            AND_ST:         next_state = WB_RD_ST;
            ADDI_ST:        next_state = WB_RT_OV_ST;
            ADDIU_ST:       next_state = WB_RT_ST;
            // ov is also read by the signal generator, there to hold off reg_write
            WB_RD_OV_ST,
            WB_RT_OV_ST:    next_state = ov ? OVERFLOW_EXC_ST : FETCH_WAIT_ST;
            SHIFT_IMM_ST,
            SHIFT_VAR_ST:   next_state = SHIFT_OP_ST;
            SHIFT_OP_ST:    next_state = SHIFT_WB_ST;
            MEM_ADDR_ST:    next_state = MEM_WAIT_ST;
            MEM_WAIT_ST:    next_state = wait_done ? mem_class : MEM_WAIT_ST;
            LOAD_WORD_ST,
            LOAD_HALF_ST,
            LOAD_BYTE_ST:   next_state = LOAD_WB_ST;
            JAL_ST:         next_state = JAL_WB_ST;
            OPCODE_EXC_ST,
            OVERFLOW_EXC_ST: next_state = wait_done ? EPC_ST : state;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH_WAIT_ST;
            wait_cnt <= '0;
        end else begin
            state    <= next_state;
            wait_cnt <= (in_wait && !wait_done) ? wait_cnt + 1'b1 : '0;
        end
    end

    // Instruction class held until the execution states need it
    always_ff @(posedge clk) begin
        if (state == DISPATCH_ST) begin
            mem_class <= dispatch_state;
            shift_op  <= shift_op_in;
        end
    end

endmodule

/* hdl/ctrl_signal_gen.sv */
module ctrl_signal_gen (
    input  ctrl_pkg::state_t    state,
    input  ctrl_pkg::shift_op_t shift_op,
    input  logic                lt,
    input  logic                ov,
    output logic                pc_write,
    output logic                branch,
    output logic                mem_wr,
    output logic                ir_write,
    output logic                a_write,
    output logic                b_write,
    output logic                mdr_write,
    output logic                aluout_write,
    output logic                epc_write,
    output logic                reg_write,
    output logic                shift_src,
    output ctrl_pkg::src_a_t    alu_src_a,
    output ctrl_pkg::src_b_t    alu_src_b,
    output ctrl_pkg::alu_op_t   alu_op,
    output ctrl_pkg::reg_dst_t  reg_dst,
    output ctrl_pkg::wdata_sel_t reg_wdata_sel,
    output ctrl_pkg::addr_sel_t iord,
    output ctrl_pkg::pc_src_t   pc_src,
    output ctrl_pkg::size_sel_t mem_to_mdr,
    output ctrl_pkg::size_sel_t b_to_mem,
    output ctrl_pkg::shift_op_t shift_ctrl,
    output ctrl_pkg::cause_t    except_cause
);
    import ctrl_pkg::*;

    function automatic size_sel_t access_size(state_t s);
        case (s)
            LOAD_HALF_ST, STORE_HALF_ST: return SIZE_HALF;
            LOAD_BYTE_ST, STORE_BYTE_ST: return SIZE_BYTE;
            default:                     return SIZE_WORD;
        endcase
    endfunction

    always_comb begin
        pc_write      = 1'b0;
        branch        = 1'b0;
        mem_wr        = 1'b0;
        ir_write      = 1'b0;
        a_write       = 1'b0;
        b_write       = 1'b0;
        mdr_write     = 1'b0;
        aluout_write  = 1'b0;
        epc_write     = 1'b0;
        reg_write     = 1'b0;
        shift_src     = 1'b0;
        alu_src_a     = SRC_A_PC;
        alu_src_b     = SRC_B_REG;
        alu_op        = ALU_PASS;
        reg_dst       = DST_RT;
        reg_wdata_sel = WD_ALUOUT;
        iord          = ADDR_PC;
        pc_src        = PC_ALU;
        mem_to_mdr    = SIZE_WORD;
        b_to_mem      = SIZE_WORD;
        shift_ctrl    = SHIFT_NONE;
        except_cause  = CAUSE_OPCODE;
        case (state)
            FETCH_WAIT_ST, FETCH_ST: begin  // PC + 4 during the instruction read
                alu_src_b = SRC_B_FOUR;
                alu_op    = ALU_ADD;
                ir_write  = (state == FETCH_ST);
                pc_write  = (state == FETCH_ST);
            end
            DECODE_ST: begin
                a_write = 1'b1;
                b_write = 1'b1;
            end
            ADD_ST, SUB_ST, AND_ST: begin
                alu_src_a    = SRC_A_REG;
                aluout_write = 1'b1;
                alu_op       = (state == SUB_ST) ? ALU_SUB :
                               (state == AND_ST) ? ALU_AND : ALU_ADD;
            end
            ADDI_ST, ADDIU_ST, MEM_ADDR_ST: begin
                alu_src_a    = SRC_A_REG;
                alu_src_b    = SRC_B_IMM;
                alu_op       = ALU_ADD;
                aluout_write = 1'b1;
            end
            WB_RD_OV_ST, WB_RD_ST: begin
                reg_write = !(ov && state == WB_RD_OV_ST);
                reg_dst   = DST_RD;
            end
            WB_RT_OV_ST, WB_RT_ST: reg_write = !(ov && state == WB_RT_OV_ST);
            SLT_ST, SLTI_ST: begin
                alu_src_a     = SRC_A_REG;
                alu_op        = ALU_SLT;
                reg_write     = 1'b1;
                reg_wdata_sel = lt ? WD_ONE : WD_ZERO;
                if (state == SLT_ST) begin
                    reg_dst = DST_RD;
                end else begin
                    alu_src_b = SRC_B_IMM;
                end
            end
            SHIFT_IMM_ST, SHIFT_VAR_ST: begin
                shift_ctrl = SHIFT_LOAD;
                shift_src  = (state == SHIFT_VAR_ST);  // Amount from rs
            end
            SHIFT_OP_ST: shift_ctrl = shift_op;
            SHIFT_WB_ST: begin
                reg_write     = 1'b1;
                reg_dst       = DST_RD;
                reg_wdata_sel = WD_SHIFT;
            end
            MEM_WAIT_ST: iord = ADDR_ALUOUT;
            LOAD_WORD_ST, LOAD_HALF_ST, LOAD_BYTE_ST: begin
                iord       = ADDR_ALUOUT;
                mdr_write  = 1'b1;
                mem_to_mdr = access_size(state);
            end
            LOAD_WB_ST: begin
                reg_write     = 1'b1;
                reg_wdata_sel = WD_MDR;
            end
            STORE_WORD_ST, STORE_HALF_ST, STORE_BYTE_ST: begin
                iord     = ADDR_ALUOUT;
                mem_wr   = 1'b1;
                b_to_mem = access_size(state);
            end
            JAL_ST: aluout_write = 1'b1;  // Return address
            JUMP_ST, JAL_WB_ST: begin
                pc_write = 1'b1;
                branch   = 1'b1;
                pc_src   = PC_JUMP;
                if (state == JAL_WB_ST) begin
                    reg_write = 1'b1;
                    reg_dst   = DST_RA;
                end
            end
            JR_ST: begin
                alu_src_a = SRC_A_REG;
                pc_write  = 1'b1;
                branch    = 1'b1;
            end
            OPCODE_EXC_ST, OVERFLOW_EXC_ST, EPC_ST: begin
                alu_src_b = SRC_B_FOUR;  // EPC gets PC - 4
                alu_op    = ALU_SUB;
                iord      = ADDR_EXC_VECTOR;
                if (state == OVERFLOW_EXC_ST) begin
                    except_cause = CAUSE_OVERFLOW;
                end
                if (state == EPC_ST) begin
                    epc_write = 1'b1;
                    pc_write  = 1'b1;
                    pc_src    = PC_EPC_VECTOR;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/instr_decoder.sv */
module instr_decoder (
    input  isa_pkg::opcode_t    opcode,
    input  isa_pkg::funct_t     funct,
    output ctrl_pkg::state_t    dispatch_state,
    output ctrl_pkg::shift_op_t shift_op
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    state_t shift_entry;

    assign shift_entry = funct[2] ? SHIFT_VAR_ST : SHIFT_IMM_ST;  // Bit 2 set on sllv/srav

    // Loads and stores return their select state
    always_comb begin
        dispatch_state = OPCODE_EXC_ST;
        shift_op       = SHIFT_NONE;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD: dispatch_state = ADD_ST;
                    FN_SUB: dispatch_state = SUB_ST;
                    FN_AND: dispatch_state = AND_ST;
                    FN_SLT: dispatch_state = SLT_ST;
                    FN_JR:  dispatch_state = JR_ST;
                    FN_SLL, FN_SLLV: begin
                        dispatch_state = shift_entry;
                        shift_op       = SHIFT_LEFT;
                    end
                    FN_SRL: begin
                        dispatch_state = shift_entry;
                        shift_op       = SHIFT_RIGHT_LOGIC;
                    end
                    FN_SRA, FN_SRAV: begin
                        dispatch_state = shift_entry;
                        shift_op       = SHIFT_RIGHT_ARITH;
                    end
                    default: ;
                endcase
            end
            OP_ADDI:  dispatch_state = ADDI_ST;
            OP_ADDIU: dispatch_state = ADDIU_ST;
            OP_SLTI:  dispatch_state = SLTI_ST;
            OP_LW:    dispatch_state = LOAD_WORD_ST;
            OP_LH:    dispatch_state = LOAD_HALF_ST;
            OP_LB:    dispatch_state = LOAD_BYTE_ST;
            OP_SW:    dispatch_state = STORE_WORD_ST;
            OP_SH:    dispatch_state = STORE_HALF_ST;
            OP_SB:    dispatch_state = STORE_BYTE_ST;
            OP_J:     dispatch_state = JUMP_ST;
            OP_JAL:   dispatch_state = JAL_ST;
            default: ;
        endcase
    end

endmodule

/* hdl/isa_pkg.sv */
package isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_LB    = 6'h20;
    localparam opcode_t OP_LH    = 6'h21;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SB    = 6'h28;
    localparam opcode_t OP_SH    = 6'h29;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module control_unit_tb -o control_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/control_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1

/* verif/control_unit_tb.sv */
module control_unit_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_SLT, K_SLL, K_SLLV, K_SRL, K_SRA, K_SRAV, K_JR,
        K_ADDI, K_ADDIU, K_SLTI, K_LW, K_LH, K_LB, K_SW, K_SH, K_SB, K_J, K_JAL,
        K_BAD
    } kind_t;

    localparam int N_INSTR      = 300;
    localparam int RESET_CYCLES = 8;
    localparam int EXEC_START   = 3;  // Fetch, decode, dispatch
    localparam int NUM_KEPT     = int'(K_BAD);
    // Overflow on add is the longest path
    localparam int MAX_INSTR    = FETCH_WAIT + EXEC_START + 2 + EXC_WAIT + 1;
    localparam int TIMEOUT_CYCLES = N_INSTR * MAX_INSTR + RESET_CYCLES + FETCH_WAIT + 1;

    logic       clk;
    logic       reset;
    opcode_t    opcode;
    funct_t     funct;
    logic       ov;
    logic       lt;
    logic       pc_write, branch, mem_wr, ir_write, a_write, b_write;
    logic       mdr_write, aluout_write, epc_write, reg_write, shift_src;
    src_a_t     alu_src_a;
    src_b_t     alu_src_b;
    alu_op_t    alu_op;
    reg_dst_t   reg_dst;
    wdata_sel_t reg_wdata_sel;
    addr_sel_t  iord;
    pc_src_t    pc_src;
    size_sel_t  mem_to_mdr;
    size_sel_t  b_to_mem;
    shift_op_t  shift_ctrl;
    cause_t     except_cause;
    logic [8:0] write_enables;

    // Expected behavior of the current instruction by cycle index from the fetch
    int         exp_len, reg_idx, mem_idx, mdr_idx, pc_idx, exc_idx, shift_idx;
    reg_dst_t   exp_dst;
    wdata_sel_t exp_wd;
    size_sel_t  exp_size;
    pc_src_t    exp_pc_src;
    logic       exp_branch;
    logic       exp_epc;
    cause_t     exp_cause;
    shift_op_t  exp_shift;
    logic       exp_shift_src;

    int mismatch_cnt = 0;
    int other_cnt    = 0;
    int cur_instr    = -1;
    int cur_idx      = 0;
    int cycle_cnt    = 0;

    assign write_enables = {pc_write, mem_wr, ir_write, a_write, b_write, mdr_write,
                            aluout_write, epc_write, reg_write};

    tb_clock u_clock (.clk(clk));

    control_unit u_dut (.*);

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h (instruction %0d, cycle %0d)",
                     name, got, exp, cur_instr, cur_idx);
        end
    endtask

    // PC + 4 through the ALU while the instruction is read
    task automatic verify_fetch();
        check_val("pc_write", 32'(pc_write), 32'h1);
        check_val("iord", 32'(iord), 32'(ADDR_PC));
        check_val("alu_src_a", 32'(alu_src_a), 32'(SRC_A_PC));
        check_val("alu_src_b", 32'(alu_src_b), 32'(SRC_B_FOUR));
        check_val("alu_op", 32'(alu_op), 32'(ALU_ADD));
    endtask

    task automatic drive_instr(input kind_t k);
        opcode_t op;
        funct_t  fn;
        op = OP_RTYPE;
        fn = funct_t'($urandom);  // Don't care outside R-type
        case (k)
            K_ADD:   fn = FN_ADD;
            K_SUB:   fn = FN_SUB;
            K_AND:   fn = FN_AND;
            K_SLT:   fn = FN_SLT;
            K_SLL:   fn = FN_SLL;
            K_SLLV:  fn = FN_SLLV;
            K_SRL:   fn = FN_SRL;
            K_SRA:   fn = FN_SRA;
            K_SRAV:  fn = FN_SRAV;
            K_JR:    fn = FN_JR;
            K_ADDI:  op = OP_ADDI;
            K_ADDIU: op = OP_ADDIU;
            K_SLTI:  op = OP_SLTI;
            K_LW:    op = OP_LW;
            K_LH:    op = OP_LH;
            K_LB:    op = OP_LB;
            K_SW:    op = OP_SW;
            K_SH:    op = OP_SH;
            K_SB:    op = OP_SB;
            K_J:     op = OP_J;
            K_JAL:   op = OP_JAL;
            default: begin
                do begin
                    op = opcode_t'($urandom);
                    fn = funct_t'($urandom);
                end while ((op == OP_RTYPE) ?
                           (fn inside {FN_ADD, FN_SUB, FN_AND, FN_SLT, FN_SLL, FN_SLLV,
                                       FN_SRL, FN_SRA, FN_SRAV, FN_JR}) :
                           (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_LW, OP_LH, OP_LB,
                                       OP_SW, OP_SH, OP_SB, OP_J, OP_JAL}));
            end
        endcase
        opcode = op;
        funct  = fn;
        ov     = 1'($urandom);
        lt     = 1'($urandom);
    endtask

    task automatic raise_exception(input int start, input cause_t cause);
        exc_idx    = start;
        exp_cause  = cause;
        pc_idx     = start + EXC_WAIT;  // EPC cycle follows the wait
        exp_pc_src = PC_EPC_VECTOR;
        exp_epc    = 1'b1;
    endtask

    task automatic expect_instr(input kind_t k, input logic ov_v, input logic lt_v);
        reg_idx       = -1;
        mem_idx       = -1;
        mdr_idx       = -1;
        pc_idx        = -1;
        exc_idx       = -1;
        shift_idx     = -1;
        exp_dst       = DST_RT;
        exp_wd        = WD_ALUOUT;
        exp_pc_src    = PC_ALU;
        exp_branch    = 1'b0;
        exp_epc       = 1'b0;
        exp_cause     = CAUSE_OPCODE;
        exp_shift     = SHIFT_NONE;
        exp_shift_src = 1'b0;
        exp_size      = (k inside {K_LH, K_SH}) ? SIZE_HALF :
                        (k inside {K_LB, K_SB}) ? SIZE_BYTE : SIZE_WORD;
        case (k)
            K_ADD, K_SUB, K_AND, K_ADDI, K_ADDIU: begin
                exp_len = 2;
                exp_dst = (k inside {K_ADDI, K_ADDIU}) ? DST_RT : DST_RD;
                if (ov_v && (k inside {K_ADD, K_SUB, K_ADDI})) begin
                    exp_len = 2 + EXC_WAIT + 1;
                    raise_exception(EXEC_START + 2, CAUSE_OVERFLOW);
                end else begin
                    reg_idx = EXEC_START + 1;
                end
            end
            K_SLT, K_SLTI: begin
                exp_len = 1;
                reg_idx = EXEC_START;
                exp_dst = (k == K_SLT) ? DST_RD : DST_RT;
                exp_wd  = lt_v ? WD_ONE : WD_ZERO;
            end
            K_SLL, K_SLLV, K_SRL, K_SRA, K_SRAV: begin
                exp_len       = 3;
                shift_idx     = EXEC_START + 1;
                reg_idx       = EXEC_START + 2;
                exp_dst       = DST_RD;
                exp_wd        = WD_SHIFT;
                exp_shift     = (k inside {K_SLL, K_SLLV}) ? SHIFT_LEFT :
                                (k == K_SRL) ? SHIFT_RIGHT_LOGIC : SHIFT_RIGHT_ARITH;
                exp_shift_src = (k inside {K_SLLV, K_SRAV});  // Amount from rs
            end
            K_LW, K_LH, K_LB: begin
                exp_len = 1 + MEM_WAIT + 2;
                mdr_idx = EXEC_START + 1 + MEM_WAIT;
                reg_idx = mdr_idx + 1;
                exp_wd  = WD_MDR;
            end
            K_SW, K_SH, K_SB: begin
                exp_len = 1 + MEM_WAIT + 1;
                mem_idx = EXEC_START + 1 + MEM_WAIT;
            end
            K_J, K_JR: begin
                exp_len    = 1;
                pc_idx     = EXEC_START;
                exp_branch = 1'b1;
                exp_pc_src = (k == K_J) ? PC_JUMP : PC_ALU;
            end
            K_JAL: begin
                exp_len    = 2;
                pc_idx     = EXEC_START + 1;
                reg_idx    = pc_idx;  // Link written with the jump
                exp_dst    = DST_RA;
                exp_branch = 1'b1;
                exp_pc_src = PC_JUMP;
            end
            default: begin
                exp_len = EXC_WAIT + 1;
                raise_exception(EXEC_START, CAUSE_OPCODE);
            end
        endcase
    endtask

    task automatic check_cycle(input int idx);
        check_val("a_write", 32'(a_write), 32'(idx == 1));
        check_val("b_write", 32'(b_write), 32'(idx == 1));
        check_val("reg_write", 32'(reg_write), 32'(idx == reg_idx));
        if (idx == reg_idx) begin
            check_val("reg_dst", 32'(reg_dst), 32'(exp_dst));
            check_val("reg_wdata_sel", 32'(reg_wdata_sel), 32'(exp_wd));
        end
        check_val("mem_wr", 32'(mem_wr), 32'(idx == mem_idx));
        if (idx == mem_idx) begin
            check_val("b_to_mem", 32'(b_to_mem), 32'(exp_size));
        end
        check_val("mdr_write", 32'(mdr_write), 32'(idx == mdr_idx));
        if (idx == mdr_idx) begin
            check_val("mem_to_mdr", 32'(mem_to_mdr), 32'(exp_size));
        end
        check_val("pc_write", 32'(pc_write), 32'(idx == pc_idx));
        if (idx == pc_idx) begin
            check_val("pc_src", 32'(pc_src), 32'(exp_pc_src));
        end
        check_val("branch", 32'(branch), 32'(exp_branch && idx == pc_idx));
        check_val("epc_write", 32'(epc_write), 32'(exp_epc && idx == pc_idx));
        if (exc_idx >= 0 && idx >= exc_idx && idx < exc_idx + EXC_WAIT) begin
            check_val("except_cause", 32'(except_cause), 32'(exp_cause));
        end
        if (idx == shift_idx) begin
            check_val("shift_ctrl", 32'(shift_ctrl), 32'(exp_shift));
        end
        check_val("shift_src", 32'(shift_src), 32'(exp_shift_src && idx == EXEC_START));
        if (idx >= EXEC_START + exp_len) begin  // Fetch wait of the next instruction
            check_val("iord", 32'(iord), 32'(ADDR_PC));
            check_val("aluout_write", 32'(aluout_write), 32'h0);
        end
    endtask

    initial begin
        kind_t kind;
        int    idx;
        reset  = 1'b1;
        opcode = '0;
        funct  = '0;
        ov     = 1'b0;
        lt     = 1'b0;
        void'($urandom(32'h1d4d3d36));

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_val("write_enables", 32'(write_enables), 32'h0);
        end
        reset = 1'b0;

        // Fetch wait straight after reset
        idx = 0;
        do begin
            @(negedge clk);
            idx++;
            cur_idx = idx;
            if (!ir_write) begin
                check_val("write_enables", 32'(write_enables), 32'h0);
                check_val("iord", 32'(iord), 32'(ADDR_PC));
            end
        end while (!ir_write);
        check_val("first ir_write delay", 32'(idx), 32'(FETCH_WAIT));
        verify_fetch();

        for (int n = 0; n < N_INSTR; n++) begin
            cur_instr = n;
            kind = ($urandom % 8 == 0) ? K_BAD : kind_t'($urandom % NUM_KEPT);
            drive_instr(kind);
            expect_instr(kind, ov, lt);
            idx = 0;
            do begin
                @(negedge clk);
                idx++;
                cur_idx = idx;
                if (!ir_write) begin
                    check_cycle(idx);
                end
            end while (!ir_write);
            check_val("ir_write period", 32'(idx), 32'(FETCH_WAIT + EXEC_START + exp_len));
            verify_fetch();  // With the next fetch
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt + other_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            other_cnt++;
            $display("error: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

/* verif/tb_clock.sv */
module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 5;  // 10 time units per cycle

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

/* vlog.f */
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/ctrl_sequencer.sv
hdl/ctrl_signal_gen.sv
hdl/control_unit.sv
verif/tb_clock.sv
verif/control_unit_tb.sv
